// ==== sound_bus_decode.sv ====
/*
  Address decode for the sound CPU. Selects are registered one clock
  after the bus. The master must hold addr, data and strobes for at
  least four clocks. Bank and rate-select only load on a cen_bus clock
  inside a held write, so short writes may be missed.
*/
`include "sound_defs.svh"

module sound_bus_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SND_AW-1:0]      addr,
    input  logic [`SND_DW-1:0]      cpu_dout,
    input  logic                    mreq_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    cen_bus,
    output logic [`SND_ROM_AW-1:0]  rom_addr,
    output logic                    rom_cs,
    output logic                    fm_cs,
    output logic                    oki_cs,
    output logic                    ram_we,
    output sound_pkg::dev_sel_t     dev_sel,
    output logic                    oki_ss,
    output logic                    fm_wr_n,
    output logic                    oki_wr_n
);

    logic rom_hit, ram_hit, io_hit;
    logic bank_cs, rate_cs, wr_q, bank;
    sound_pkg::dev_sel_t sel_d;

    assign rom_hit = !addr[15] || addr[15:14] == 2'b10;   // fixed + banked window
    assign ram_hit = addr[15:12] == `SND_RAM_BASE;
    assign io_hit  = addr[15:12] == `SND_IO_BASE;

    always_comb begin
        sel_d = sound_pkg::dev_none;
        if (!mreq_n) begin
            if (rom_hit && !rd_n) begin
                sel_d = sound_pkg::dev_rom;
            end else if (ram_hit && !rd_n) begin
                sel_d = sound_pkg::dev_ram;   // writes only raise ram_we
            end else if (io_hit) begin
                case (addr[3:1])
                    3'd0:    sel_d = sound_pkg::dev_fm;
                    3'd1:    sel_d = sound_pkg::dev_oki;
                    3'd4:    sel_d = sound_pkg::dev_latch0;
                    3'd5:    sel_d = sound_pkg::dev_latch1;
                    default: sel_d = sound_pkg::dev_none;   // bank/rate read back as ff
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            fm_cs    <= 1'b0;
            oki_cs   <= 1'b0;
            bank_cs  <= 1'b0;
            rate_cs  <= 1'b0;
            ram_we   <= 1'b0;
            wr_q     <= 1'b0;
            dev_sel  <= sound_pkg::dev_none;
            rom_addr <= '0;
        end else begin
            rom_cs   <= sel_d == sound_pkg::dev_rom;
            fm_cs    <= sel_d == sound_pkg::dev_fm;
            oki_cs   <= sel_d == sound_pkg::dev_oki;
            bank_cs  <= !mreq_n && io_hit && addr[3:1] == 3'd2;
            rate_cs  <= !mreq_n && io_hit && addr[3:1] == 3'd3;
            ram_we   <= !mreq_n && ram_hit && !wr_n;
            wr_q     <= !mreq_n && !wr_n;
            dev_sel  <= sel_d;
            rom_addr <= addr[15] ? {1'b1, bank, addr[13:0]} : {1'b0, addr[14:0]};
        end
    end

    // strobes built from aligned registers, no glitch between accesses
    assign fm_wr_n  = !(fm_cs && wr_q);
    assign oki_wr_n = !(oki_cs && wr_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank   <= 1'b0;
            oki_ss <= 1'b0;
        end else if (wr_q && cen_bus) begin
            if (bank_cs) bank <= cpu_dout[0];
            if (rate_cs) oki_ss <= cpu_dout[0];   // adpcm sample rate
        end
    end

    // a bus cycle is a read or a write, never both
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !mreq_n |-> rd_n || wr_n);

endmodule

// ==== sound_cen_gen.sv ====
/*
  Fractional clock enables. Each output is a one-clock pulse, N pulses
  every M clocks, with jitter of one clock. Ratios must stay below one.
*/
`include "sound_defs.svh"

module sound_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen_bus,
    output logic cen_oki
);

    localparam int unsigned max_m = (`SND_CEN_M > `SND_OKI_M) ? `SND_CEN_M : `SND_OKI_M;
    localparam int unsigned acc_w = $clog2(max_m) + 1;   // room for acc + n

    wire [1:0] pulse;

    // index 0 drives the bus enable, index 1 the adpcm enable
    for (genvar i = 0; i < 2; i++) begin : g_acc
        localparam int unsigned n = (i == 0) ? `SND_CEN_N : `SND_OKI_N;
        localparam int unsigned m = (i == 0) ? `SND_CEN_M : `SND_OKI_M;

        logic [acc_w-1:0] acc, nxt;
        logic cen_q;

        assign nxt = acc + acc_w'(n);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                acc   <= '0;
                cen_q <= 1'b0;
            end else if (nxt >= acc_w'(m)) begin
                acc   <= nxt - acc_w'(m);   // keep the remainder
                cen_q <= 1'b1;
            end else begin
                acc   <= nxt;
                cen_q <= 1'b0;
            end
        end

        assign pulse[i] = cen_q;
    end

    assign cen_bus = pulse[0];
    assign cen_oki = pulse[1];

endmodule

// ==== sound_defs.svh ====
/*
  Address map, bus widths, mixer gains and clock-enable ratios.
  The gains are 4.4 fixed point. The enable ratios assume N < M.
  The RAM and I/O bases compare against address bits 15:12 only.
*/
`ifndef SOUND_DEFS_SVH
`define SOUND_DEFS_SVH

// CPU bus
`define SND_AW       16
`define SND_DW       8
`define SND_ROM_AW   16
`define SND_RAM_AW   11

// region decode on the upper nibble
`define SND_RAM_BASE 4'hD
`define SND_IO_BASE  4'hF

// mixer gains, 4.4 fixed point
`define SND_FM_GAIN  8'h08   // 0.5
`define SND_PCM_GAIN 8'h10   // 1.0

// cpu bus enable, N pulses every M clocks
`define SND_CEN_N    3
`define SND_CEN_M    40

// adpcm enable
`define SND_OKI_N    1
`define SND_OKI_M    48

`endif

// ==== sound_mixer.sv ====
/*
  One output channel of the stereo mixer. ch0 is a full-width FM
  sample, ch1 the narrower ADPCM sample. Gains are unsigned 4.4, so
  8'h10 is unity and 8'h00 mutes the channel. The sum is saturated
  to the sample range and registered once.
*/
module sound_mixer (
    input  logic                clk,
    input  logic                rst,
    input  sound_pkg::sample_t  ch0,
    input  sound_pkg::pcm_t     ch1,
    input  logic [7:0]          gain0,
    input  logic [7:0]          gain1,
    output sound_pkg::sample_t  mixed
);

    localparam int ext_w = $bits(sound_pkg::sample_t) - $bits(sound_pkg::pcm_t);
    localparam logic signed [21:0] sat_max = 22'sd32767;
    localparam logic signed [21:0] sat_min = -22'sd32768;

    logic signed [15:0] ch1_ext;
    logic signed [8:0]  g0, g1;
    logic signed [24:0] prod0, prod1;
    logic signed [25:0] sum;
    logic signed [21:0] sum_sh;

    assign ch1_ext = {{ext_w{ch1[$bits(sound_pkg::pcm_t)-1]}}, ch1};

    // zero-extend the gains so they stay positive in signed math
    assign g0 = {1'b0, gain0};
    assign g1 = {1'b0, gain1};

    assign prod0  = ch0 * g0;
    assign prod1  = ch1_ext * g1;
    assign sum    = prod0 + prod1;
    assign sum_sh = sum[25:4];   // drop the 4.4 fraction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixed <= '0;
        end else if (sum_sh > sat_max) begin
            mixed <= 16'sh7fff;
        end else if (sum_sh < sat_min) begin
            mixed <= 16'sh8000;
        end else begin
            mixed <= sum_sh[15:0];
        end
    end

    // non-negative inputs never mix to a negative sample
    a_no_neg: assert property (@(posedge clk) disable iff (rst)
        (!ch0[15] && !ch1[13]) |=> !mixed[15]);

endmodule

// ==== sound_pkg.sv ====
/*
  Shared types for the sound board glue.
  sample_t is the mixed output width. pcm_t matches the ADPCM
  decoder output and gets sign-extended in the mixer.
*/
package sound_pkg;

    // full-scale audio sample
    typedef logic signed [15:0] sample_t;

    // adpcm decoder output
    typedef logic signed [13:0] pcm_t;

    // source forwarded by the read mux
    typedef enum logic [2:0] {
        dev_none   = 3'd0,
        dev_fm     = 3'd1,
        dev_oki    = 3'd2,
        dev_latch0 = 3'd3,
        dev_latch1 = 3'd4,
        dev_ram    = 3'd5,
        dev_rom    = 3'd6
    } dev_sel_t;

endpackage

// ==== sound_read_mux.sv ====
/*
  Read data path for the sound CPU. din is valid three clocks after
  the bus inputs, so the CPU enable must be slow enough to sample it.
  rom_wait is combinational and needs rom_ok high on two clocks
  in a row before it releases.
*/
`include "sound_defs.svh"

module sound_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  sound_pkg::dev_sel_t dev_sel,
    input  logic [`SND_DW-1:0]  snd_latch0,
    input  logic [`SND_DW-1:0]  snd_latch1,
    input  logic [`SND_DW-1:0]  fm_dout,
    input  logic [`SND_DW-1:0]  oki_dout,
    input  logic [`SND_DW-1:0]  ram_q,
    input  logic [`SND_DW-1:0]  rom_data,
    input  logic                rom_cs,
    input  logic                rom_ok,
    output logic [`SND_DW-1:0]  din,
    output logic                rom_wait
);

    logic [`SND_DW-1:0] cmd_latch, dev_latch, mem_latch;
    logic cmd_cs, dev_cs, mem_cs, rom_ok2;

    // group latches, data only
    always_ff @(posedge clk) begin
        cmd_latch <= dev_sel == sound_pkg::dev_latch0 ? snd_latch0 : snd_latch1;
        dev_latch <= dev_sel == sound_pkg::dev_fm ? fm_dout : oki_dout;
        mem_latch <= dev_sel == sound_pkg::dev_ram ? ram_q : rom_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_cs  <= 1'b0;
            dev_cs  <= 1'b0;
            mem_cs  <= 1'b0;
            rom_ok2 <= 1'b0;
            din     <= 8'hff;
        end else begin
            cmd_cs  <= dev_sel inside {sound_pkg::dev_latch0, sound_pkg::dev_latch1};
            dev_cs  <= dev_sel inside {sound_pkg::dev_fm, sound_pkg::dev_oki};
            mem_cs  <= dev_sel inside {sound_pkg::dev_ram, sound_pkg::dev_rom};
            rom_ok2 <= rom_ok;
            // devices win over commands, commands over memory
            if (dev_cs) begin
                din <= dev_latch;
            end else if (cmd_cs) begin
                din <= cmd_latch;
            end else if (mem_cs) begin
                din <= mem_latch;
            end else begin
                din <= 8'hff;   // open bus
            end
        end
    end

    assign rom_wait = rom_cs && !(rom_ok && rom_ok2);

    a_din_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(din));

endmodule

// ==== sound_top.sv ====
/*
  Sound board glue without the CPU, FM and ADPCM cores, which sit
  outside on loose ports. ROM reads stall through rom_wait only.
  The ADPCM chip select pulse stays internal, the chip sees oki_wr_n.
*/
`include "sound_defs.svh"

module sound_top (
    input  logic                    clk,
    input  logic                    rst,
    // cpu bus
    input  logic [`SND_AW-1:0]      addr,
    input  logic [`SND_DW-1:0]      cpu_dout,
    input  logic                    mreq_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    output logic [`SND_DW-1:0]      din,
    output logic                    rom_wait,
    output logic                    cen_bus,
    // main cpu
    input  logic [`SND_DW-1:0]      snd_latch0,
    input  logic [`SND_DW-1:0]      snd_latch1,
    input  logic                    enable_fm,
    input  logic                    enable_adpcm,
    // program rom
    output logic [`SND_ROM_AW-1:0]  rom_addr,
    output logic                    rom_cs,
    input  logic [`SND_DW-1:0]      rom_data,
    input  logic                    rom_ok,
    // fm chip
    output logic                    fm_cs,
    output logic                    fm_wr_n,
    output logic                    fm_a0,
    output logic [`SND_DW-1:0]      fm_din,
    input  logic [`SND_DW-1:0]      fm_dout,
    input  sound_pkg::sample_t      fm_left,
    input  sound_pkg::sample_t      fm_right,
    // adpcm chip
    output logic                    oki_wr_n,
    output logic [`SND_DW-1:0]      oki_din,
    output logic                    oki_ss,
    input  logic [`SND_DW-1:0]      oki_dout,
    input  sound_pkg::pcm_t         adpcm_snd,
    output logic                    cen_oki,
    // audio
    output sound_pkg::sample_t      left,
    output sound_pkg::sample_t      right
);

    sound_pkg::dev_sel_t dev_sel;
    logic ram_we;
    logic [`SND_DW-1:0] ram_q;
    logic [7:0] fm_gain, pcm_gain;

    assign fm_gain  = enable_fm ? `SND_FM_GAIN : 8'h00;
    assign pcm_gain = enable_adpcm ? `SND_PCM_GAIN : 8'h00;

    assign fm_a0   = addr[0];
    assign fm_din  = cpu_dout;
    assign oki_din = cpu_dout;

    sound_cen_gen u_cen (.clk(clk), .rst(rst), .cen_bus(cen_bus), .cen_oki(cen_oki));

    sound_bus_decode u_decode (
        .clk      (clk),      .rst      (rst),
        .addr     (addr),     .cpu_dout (cpu_dout),
        .mreq_n   (mreq_n),   .rd_n     (rd_n),
        .wr_n     (wr_n),     .cen_bus  (cen_bus),
        .rom_addr (rom_addr), .rom_cs   (rom_cs),
        .fm_cs    (fm_cs),    .oki_cs   (),
        .ram_we   (ram_we),   .dev_sel  (dev_sel),
        .oki_ss   (oki_ss),   .fm_wr_n  (fm_wr_n),
        .oki_wr_n (oki_wr_n)
    );

    // ram address comes straight off the bus, we is a clock late
    sound_work_ram u_ram (
        .clk   (clk),
        .addr  (addr[`SND_RAM_AW-1:0]),
        .wdata (cpu_dout),
        .we    (ram_we),
        .q     (ram_q)
    );

    sound_read_mux u_mux (
        .clk        (clk),        .rst      (rst),
        .dev_sel    (dev_sel),
        .snd_latch0 (snd_latch0), .snd_latch1 (snd_latch1),
        .fm_dout    (fm_dout),    .oki_dout   (oki_dout),
        .ram_q      (ram_q),      .rom_data   (rom_data),
        .rom_cs     (rom_cs),     .rom_ok     (rom_ok),
        .din        (din),        .rom_wait   (rom_wait)
    );

    // both channels share the mono adpcm output
    sound_mixer u_mix_left (
        .clk   (clk),     .rst   (rst),
        .ch0   (fm_left), .ch1   (adpcm_snd),
        .gain0 (fm_gain), .gain1 (pcm_gain),
        .mixed (left)
    );

    sound_mixer u_mix_right (
        .clk   (clk),      .rst   (rst),
        .ch0   (fm_right), .ch1   (adpcm_snd),
        .gain0 (fm_gain),  .gain1 (pcm_gain),
        .mixed (right)
    );

endmodule

// ==== sound_work_ram.sv ====
/*
  Work RAM, 2 KB, single port. Read data is registered and shows the
  old contents on a write cycle. No reset, contents start unknown.
*/
`include "sound_defs.svh"

module sound_work_ram (
    input  logic                    clk,
    input  logic [`SND_RAM_AW-1:0]  addr,
    input  logic [`SND_DW-1:0]      wdata,
    input  logic                    we,
    output logic [`SND_DW-1:0]      q
);

    localparam int depth = 2 ** `SND_RAM_AW;

    logic [`SND_DW-1:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];   // read before write
    end

    // decode drives we a clock after the strobe, addr must still be held
    a_addr_known: assert property (@(posedge clk)
        we |-> !$isunknown(addr));

endmodule

// ==== tb.f ====
+incdir+.
sound_pkg.sv
sound_bus_decode.sv
sound_work_ram.sv
sound_read_mux.sv
sound_mixer.sv
sound_cen_gen.sv
sound_top.sv
tb_sound_top.sv

// ==== tb_sound_top.sv ====
/*
  Random testbench for sound_top with a fixed seed. Plays the sound CPU
  bus master, the program ROM and the FM and ADPCM chips. Register
  writes are held until a cen_bus pulse falls inside them.
*/
`include "sound_defs.svh"

module tb_sound_top;

    localparam int timeout_cycles = 400 * 60 + 6000;   // worst access length plus margin

    logic clk, rst, mreq_n, rd_n, wr_n, enable_fm, enable_adpcm;
    logic [15:0] addr, rom_addr;
    logic [7:0] cpu_dout, snd_latch0, snd_latch1, fm_dout, oki_dout;
    logic [7:0] rom_data = 8'h00;
    logic rom_ok = 1'b0;
    logic [7:0] din, fm_din, oki_din;
    logic rom_wait, cen_bus, rom_cs, fm_cs, fm_wr_n, fm_a0, oki_wr_n, oki_ss, cen_oki;
    sound_pkg::sample_t fm_left, fm_right, left, right;
    sound_pkg::pcm_t adpcm_snd;

    logic [7:0] ram_m [0:2047];   // reference model of the work RAM
    logic [10:0] ram_used [$];
    logic bank_m, rate_m, ok_prev;
    logic [7:0] rom_value;
    int rom_delay, rom_max_delay;
    int checks = 0, errors = 0, cycles = 0, mark_checks, mark_errors;
    int en_cycles = 0, bus_pulses = 0, oki_pulses = 0;

    sound_top dut0 (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, a bus access never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    // fixed lower 32 KB, then a 16 KB window picked by the bank bit
    function automatic logic [15:0] rom_map(input logic [15:0] a, input logic bank);
        if (a < 16'h8000) return a;
        return 16'h8000 + (bank ? 16'h4000 : 16'h0000) + (a & 16'h3fff);
    endfunction

    function automatic logic [7:0] io_expect(input logic [15:0] a);
        if (a[15:12] != 4'hF) return 8'hff;   // unmapped region
        case (a[3:1])
            3'd0: return fm_dout;
            3'd1: return oki_dout;
            3'd4: return snd_latch0;
            3'd5: return snd_latch1;
            default: return 8'hff;
        endcase
    endfunction

    function automatic int mix_model(input int fm, input int pcm, input logic en_fm,
                                     input logic en_pcm);
        int g_fm, g_pcm, sum;
        g_fm = en_fm ? `SND_FM_GAIN : 0;
        g_pcm = en_pcm ? `SND_PCM_GAIN : 0;
        sum = (fm * g_fm + pcm * g_pcm) >>> 4;   // gains are 4.4
        if (sum > 32767) return 32767;
        if (sum < -32768) return -32768;
        return sum;
    endfunction

    // program ROM, data ready after a random number of clocks
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok <= 1'b0;
            rom_delay = $urandom_range(rom_max_delay);
        end else if (!rom_ok) begin
            if (rom_delay == 0) begin
                rom_value = 8'($urandom);
                rom_data <= rom_value;
                rom_ok <= 1'b1;
            end else begin
                rom_delay--;
                rom_data <= 8'($urandom);   // not valid yet
            end
        end
    end

    // wait may release only after rom_ok was high in this clock and the last
    always @(negedge clk) begin
        if (!rst) begin
            check_value("rom_wait", rom_wait, rom_cs && !(rom_ok && ok_prev));
        end
        ok_prev = rom_ok;
    end

    // cen_bus gives N pulses in any M clocks, cen_oki one in 48
    always @(negedge clk) begin
        if (!rst) begin
            if (en_cycles > 0) begin   // first sample still shows the reset value
                bus_pulses += cen_bus;
                oki_pulses += cen_oki;
                if (en_cycles % `SND_CEN_M == 0) begin
                    check_value("cen_bus pulses", bus_pulses, `SND_CEN_N);
                    bus_pulses = 0;
                end
                if (en_cycles % `SND_OKI_M == 0) begin
                    check_value("cen_oki pulses", oki_pulses, `SND_OKI_N);
                    oki_pulses = 0;
                end
            end
            en_cycles++;
        end
    end

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        int n;
        logic seen, io;
        n = 0;
        seen = 1'b0;
        io = a[15:12] == 4'hF;
        @(posedge clk);
        addr <= a;
        cpu_dout <= d;
        mreq_n <= 1'b0;
        wr_n <= 1'b0;
        do begin
            @(negedge clk);
            if (n > 0) begin
                seen = seen || cen_bus;   // a register loads on the next edge
                check_value("fm_wr_n", fm_wr_n, !(io && a[3:1] == 3'd0));
                check_value("oki_wr_n", oki_wr_n, !(io && a[3:1] == 3'd1));
                check_value("fm_cs", fm_cs, io && a[3:1] == 3'd0);
                check_value("fm_a0", fm_a0, a[0]);
                check_value("fm_din", fm_din, d);
                check_value("oki_din", oki_din, d);
            end
            @(posedge clk);
            n++;
        end while (n < 4 || !seen);
        mreq_n <= 1'b1;   // addr and data stay put for the late RAM write
        wr_n <= 1'b1;
        if (a[15:12] == 4'hD) ram_m[a[10:0]] = d;
        if (io && a[3:1] == 3'd2) bank_m = d[0];
        if (io && a[3:1] == 3'd3) rate_m = d[0];
        @(negedge clk);
        check_value("oki_ss", oki_ss, rate_m);
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d,
                            output logic [15:0] ra);
        int n;
        n = 0;
        @(posedge clk);
        addr <= a;
        mreq_n <= 1'b0;
        rd_n <= 1'b0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (n < 3 || rom_wait);
        @(posedge clk);   // din trails the wait by a clock
        @(negedge clk);
        d = din;
        ra = rom_addr;
        check_value("fm_wr_n", fm_wr_n, 1'b1);
        check_value("oki_wr_n", oki_wr_n, 1'b1);
        @(posedge clk);
        mreq_n <= 1'b1;
        rd_n <= 1'b1;
    endtask

    initial begin
        logic [15:0] a, ra;
        logic [7:0] got;
        sound_pkg::sample_t fl, fr;
        sound_pkg::pcm_t pcm;
        void'($urandom(98017));
        rst = 1'b1;
        addr = '0;
        cpu_dout = '0;
        mreq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        snd_latch0 = '0;
        snd_latch1 = '0;
        fm_dout = '0;
        oki_dout = '0;
        enable_fm = 1'b0;
        enable_adpcm = 1'b0;
        fm_left = '0;
        fm_right = '0;
        adpcm_snd = '0;
        bank_m = 1'b0;
        rate_m = 1'b0;
        rom_max_delay = 3;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        start_test();
        check_value("din", din, 8'hff);
        check_value("rom_cs", rom_cs, 1'b0);
        check_value("fm_wr_n", fm_wr_n, 1'b1);
        check_value("oki_ss", oki_ss, 1'b0);
        check_value("left", left, 0);
        check_value("right", right, 0);
        end_test("reset");

        start_test();
        repeat (40) begin
            a = {4'hD, 12'($urandom)};
            bus_write(a, 8'($urandom));
            ram_used.push_back(a[10:0]);
        end
        repeat (40) begin
            a = {4'hD, 1'($urandom), ram_used[$urandom_range(ram_used.size() - 1)]};
            bus_read(a, got, ra);
            check_value("din", got, ram_m[a[10:0]]);
        end
        end_test("ram");

        start_test();
        repeat (12) begin
            bus_write({4'hF, 8'($urandom), 3'd2, 1'($urandom)}, 8'($urandom));   // bank
            repeat (5) begin
                a = 16'($urandom_range(16'hBFFF));
                bus_read(a, got, ra);
                check_value("rom_addr", ra, rom_map(a, bank_m));
                check_value("din", got, rom_value);
            end
        end
        end_test("rom banking");

        start_test();
        repeat (40) begin
            @(posedge clk);
            fm_dout <= 8'($urandom);
            oki_dout <= 8'($urandom);
            snd_latch0 <= 8'($urandom);
            snd_latch1 <= 8'($urandom);
            if ($urandom_range(3) == 0) begin
                a = {($urandom_range(1) ? 4'hC : 4'hE), 12'($urandom)};
            end else begin
                a = {4'hF, 8'($urandom), 3'($urandom), 1'($urandom)};
            end
            bus_read(a, got, ra);
            check_value("din", got, io_expect(a));
        end
        end_test("io reads");

        start_test();
        repeat (40) begin
            bus_write({4'hF, 8'($urandom), 3'($urandom_range(3)), 1'($urandom)}, 8'($urandom));
        end
        end_test("io writes");

        start_test();
        for (int c = 0; c < 4; c++) begin
            repeat (20) begin
                fl = sound_pkg::sample_t'($urandom);
                fr = sound_pkg::sample_t'($urandom);
                pcm = sound_pkg::pcm_t'($urandom);
                @(posedge clk);
                enable_fm <= c[0];
                enable_adpcm <= c[1];
                fm_left <= fl;
                fm_right <= fr;
                adpcm_snd <= pcm;
                @(posedge clk);
                @(negedge clk);
                check_value("left", left, mix_model(fl, pcm, c[0], c[1]));
                check_value("right", right, mix_model(fr, pcm, c[0], c[1]));
            end
        end
        end_test("mixing");

        start_test();
        rom_max_delay = 10;   // longer stalls
        repeat (30) begin
            a = 16'($urandom_range(16'h7FFF));
            bus_read(a, got, ra);
            check_value("din", got, rom_value);
        end
        end_test("rom wait");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
